// ==== hdl/eq_pkg.sv ====
package eq_pkg;

    localparam int SAMPLE_W  = 16;
    localparam int NUM_BINS  = 64;
    localparam int BIN_W     = 6;
    localparam int NUM_DATA  = 48;
    localparam int PROD_W    = 32;
    localparam int MAG_W     = 24;
    localparam int NUM_LANES = 2;

    localparam int MULT_LATENCY = 3;
    localparam int DIV_LATENCY  = PROD_W + 2; // input stage, one per quotient bit, sign stage

    // bit 0 is DC, bits 1..26 positive bins, bits 38..63 negative bins
    localparam logic [NUM_BINS-1:0] SUBCARRIER_MASK = 64'hFFFF_FFC0_07FF_FFFE;

    // bins 7, 21, 43, 57
    localparam logic [NUM_BINS-1:0] PILOT_MASK = 64'h0200_0800_0020_0080;

    localparam logic [NUM_BINS-1:0] DATA_MASK = SUBCARRIER_MASK ^ PILOT_MASK;

    localparam logic [3:0][BIN_W-1:0] PILOT_BIN = {6'd57, 6'd43, 6'd21, 6'd7};

    // 1 means the reference training value is -1 at that bin
    localparam logic [NUM_BINS-1:0] LTS_REF = 64'h0A60_5300_0056_7D4C;

    // bit n gives pilot polarity of data symbol n
    localparam logic [126:0] POLARITY =
        127'b1111111000111011000101001011111010101000010110111100111001010110011000001101101011101000110010001000000100100110100111101110000;

    // pilot order as in PILOT_BIN, bin 21 carries an inverted pilot
    localparam logic [3:0] PILOT_FLIP = 4'b0010;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] i;
        logic signed [SAMPLE_W-1:0] q;
    } cplx_t;

    typedef logic signed [PROD_W-1:0] prod_t;

    typedef logic [MAG_W-1:0] mag_t;

endpackage

// ==== hdl/chan_ram.sv ====
`timescale 1ns/1ps

module chan_ram #(
    parameter int ADDR_W = 6
) (
    input  logic              clock,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] waddr_i,
    input  eq_pkg::cplx_t     wdata_i,
    input  logic [ADDR_W-1:0] raddr_a_i,
    output eq_pkg::cplx_t     rdata_a_o,
    input  logic [ADDR_W-1:0] raddr_b_i,
    output eq_pkg::cplx_t     rdata_b_o
);

    eq_pkg::cplx_t mem [2**ADDR_W];

    always_ff @(posedge clock) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_a_o <= mem[raddr_a_i]; // old word on a same-address collision
        rdata_b_o <= mem[raddr_b_i];
    end

endmodule

// ==== hdl/lts_averager.sv ====
`timescale 1ns/1ps

module lts_averager (
    input  logic                     clock,
    input  logic                     reset,
    input  eq_pkg::cplx_t            sample_i,
    input  logic                     sample_stb_i,
    input  logic [eq_pkg::BIN_W-1:0] raddr_a_i,
    output eq_pkg::cplx_t            h_a_o,
    input  logic [eq_pkg::BIN_W-1:0] raddr_b_i,
    output eq_pkg::cplx_t            h_b_o,
    output logic                     chan_ready_o
);

    localparam int SW = eq_pkg::SAMPLE_W;

    logic [eq_pkg::BIN_W-1:0] bin_cnt;
    logic                     second;   // first training symbol is stored
    logic                     stb_d;
    logic                     avg_d;
    logic                     neg_d;
    logic [eq_pkg::BIN_W-1:0] bin_d;
    eq_pkg::cplx_t            sample_d;
    eq_pkg::cplx_t            mean;
    eq_pkg::cplx_t            wdata;
    logic [eq_pkg::BIN_W-1:0] ram_raddr_a;
    logic signed [SW:0]       sum_i;
    logic signed [SW:0]       sum_q;

    // port A looks up the stored first symbol until the channel is complete
    assign ram_raddr_a = chan_ready_o ? raddr_a_i : bin_cnt;

    chan_ram #(
        .ADDR_W(eq_pkg::BIN_W)
    ) i_chan_ram (
        .clock    (clock),
        .we_i     (stb_d),
        .waddr_i  (bin_d),
        .wdata_i  (wdata),
        .raddr_a_i(ram_raddr_a),
        .rdata_a_o(h_a_o),
        .raddr_b_i(raddr_b_i),
        .rdata_b_o(h_b_o)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            bin_cnt      <= '0;
            second       <= 1'b0;
            stb_d        <= 1'b0;
            chan_ready_o <= 1'b0;
        end else begin
            stb_d <= sample_stb_i;
            if (sample_stb_i) begin
                bin_cnt <= bin_cnt + 1'b1;
                if (bin_cnt == '1) begin
                    second <= 1'b1;
                end
            end
            if (stb_d && avg_d && bin_d == '1) begin
                chan_ready_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        sample_d <= sample_i;
        bin_d    <= bin_cnt;
        avg_d    <= second;
        neg_d    <= eq_pkg::LTS_REF[bin_cnt];
    end

    // first value arrives on port A in the cycle after the strobe
    assign sum_i = neg_d ? h_a_o.i - sample_d.i : h_a_o.i + sample_d.i;
    assign sum_q = neg_d ? h_a_o.q - sample_d.q : h_a_o.q + sample_d.q;

    assign mean.i = sum_i[SW:1];
    assign mean.q = sum_q[SW:1];

    assign wdata = avg_d ? mean : sample_d;

endmodule

// ==== hdl/pilot_correlator.sv ====
`timescale 1ns/1ps

module pilot_correlator (
    input  logic                                          clock,
    input  logic                                          reset,
    input  eq_pkg::cplx_t                                 sample_i,
    input  logic                                          sample_stb_i,
    input  logic [eq_pkg::BIN_W-1:0]                      bin_i,
    input  logic [$clog2($bits(eq_pkg::POLARITY))-1:0]    sym_idx_i,
    output logic [eq_pkg::BIN_W-1:0]                      h_raddr_o,
    input  eq_pkg::cplx_t                                 h_i,
    output eq_pkg::prod_t                                 pilot_sum_i_o,
    output eq_pkg::prod_t                                 pilot_sum_q_o,
    output logic                                          pilot_sum_stb_o
);

    localparam int SW  = eq_pkg::SAMPLE_W;
    localparam int LAT = eq_pkg::MULT_LATENCY;

    logic [1:0]            pilot_idx;
    logic                  pol;
    logic                  is_pilot;
    logic [LAT:0]          vld;
    logic [LAT:0]          last;     // marks the fourth pilot
    logic signed [SW:0]    x_i;
    logic signed [SW:0]    x_q;
    logic signed [SW:0]    a_i;
    logic signed [SW:0]    a_q;
    logic signed [SW-1:0]  b_i;
    logic signed [SW-1:0]  b_q;
    eq_pkg::prod_t         p_ii;
    eq_pkg::prod_t         p_qq;
    eq_pkg::prod_t         p_iq;
    eq_pkg::prod_t         p_qi;
    eq_pkg::prod_t         m_i;
    eq_pkg::prod_t         m_q;
    eq_pkg::prod_t         acc_i;
    eq_pkg::prod_t         acc_q;

    assign h_raddr_o = bin_i;
    assign is_pilot  = sample_stb_i && eq_pkg::PILOT_MASK[bin_i];

    always_comb begin
        pilot_idx = '0;
        for (int p = 0; p < 4; p++) begin
            if (bin_i == eq_pkg::PILOT_BIN[p]) begin
                pilot_idx = p[1:0];
            end
        end
    end

    assign pol = eq_pkg::POLARITY[sym_idx_i] ^ eq_pkg::PILOT_FLIP[pilot_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            vld             <= '0;
            acc_i           <= '0;
            acc_q           <= '0;
            pilot_sum_stb_o <= 1'b0;
        end else begin
            vld             <= {vld[LAT-1:0], is_pilot};
            pilot_sum_stb_o <= vld[LAT] && last[LAT];
            if (vld[LAT]) begin
                acc_i <= last[LAT] ? '0 : acc_i + m_i; // restart for next symbol
                acc_q <= last[LAT] ? '0 : acc_q + m_q;
            end
        end
    end

    always_ff @(posedge clock) begin
        x_i  <= pol ? -sample_i.i : sample_i.i;  // -conj(x) when polarity is set
        x_q  <= pol ? sample_i.q : -sample_i.q;
        last <= {last[LAT-1:0], bin_i == eq_pkg::PILOT_BIN[3]};
        a_i  <= x_i;
        a_q  <= x_q;
        b_i  <= h_i.i;
        b_q  <= h_i.q;
        p_ii <= a_i * b_i;
        p_qq <= a_q * b_q;
        p_iq <= a_i * b_q;
        p_qi <= a_q * b_i;
        m_i  <= p_ii - p_qq;
        m_q  <= p_iq + p_qi;
        if (vld[LAT] && last[LAT]) begin
            pilot_sum_i_o <= acc_i + m_i;
            pilot_sum_q_o <= acc_q + m_q;
        end
    end

endmodule

// ==== hdl/symbol_feeder.sv ====
`timescale 1ns/1ps

module symbol_feeder #(
    parameter int CONS_SCALE_SHIFT = 2
) (
    input  logic                     clock,
    input  logic                     reset,
    input  eq_pkg::cplx_t            sample_i,
    input  logic                     sample_stb_i,
    input  logic [eq_pkg::BIN_W-1:0] bin_i,
    output logic [eq_pkg::BIN_W-1:0] h_raddr_o,
    input  eq_pkg::cplx_t            h_i,
    output eq_pkg::prod_t            dividend_i_o,
    output eq_pkg::prod_t            dividend_q_o,
    output eq_pkg::mag_t             divisor_o,
    output logic                     div_stb_o,
    output logic [eq_pkg::BIN_W-1:0] div_bin_o
);

    localparam int SW  = eq_pkg::SAMPLE_W;
    localparam int LAT = eq_pkg::MULT_LATENCY;

    logic                     wbank;
    logic                     rbank;
    logic                     replay;
    logic [eq_pkg::BIN_W-1:0] rd_bin;
    eq_pkg::cplx_t            x;
    logic [LAT:0]             vld;
    logic [eq_pkg::BIN_W-1:0] bin_pipe [LAT+1];
    logic signed [SW-1:0]     xi;
    logic signed [SW-1:0]     xq;
    logic signed [SW-1:0]     hi;
    logic signed [SW-1:0]     hq;
    eq_pkg::prod_t            p_ii;
    eq_pkg::prod_t            p_qq;
    eq_pkg::prod_t            p_qi;
    eq_pkg::prod_t            p_iq;
    eq_pkg::prod_t            h_ii;
    eq_pkg::prod_t            h_qq;

    chan_ram #(
        .ADDR_W(eq_pkg::BIN_W + 1)
    ) i_sym_ram (
        .clock    (clock),
        .we_i     (sample_stb_i),
        .waddr_i  ({wbank, bin_i}),
        .wdata_i  (sample_i),
        .raddr_a_i({rbank, rd_bin}),
        .rdata_a_o(x),
        .raddr_b_i({rbank, rd_bin}),
        .rdata_b_o()
    );

    assign h_raddr_o = rd_bin;

    always_ff @(posedge clock) begin
        if (reset) begin
            wbank  <= 1'b0;
            rbank  <= 1'b0;
            replay <= 1'b0;
            rd_bin <= '0;
            vld    <= '0;
        end else begin
            vld <= {vld[LAT-1:0], replay};
            if (sample_stb_i && bin_i == '1) begin
                wbank  <= ~wbank;   // next symbol fills the other bank
                rbank  <= wbank;
                replay <= 1'b1;
                rd_bin <= '0;
            end else if (replay) begin
                rd_bin <= rd_bin + 1'b1;
                if (rd_bin == '1) begin
                    replay <= 1'b0;
                end
            end
        end
    end

    // x * conj(h) and |h|^2
    always_ff @(posedge clock) begin
        xi           <= x.i;
        xq           <= x.q;
        hi           <= h_i.i;
        hq           <= h_i.q;
        p_ii         <= xi * hi;
        p_qq         <= xq * hq;
        p_qi         <= xq * hi;
        p_iq         <= xi * hq;
        h_ii         <= hi * hi;
        h_qq         <= hq * hq;
        dividend_i_o <= (p_ii + p_qq) <<< (CONS_SCALE_SHIFT + 1);
        dividend_q_o <= (p_qi - p_iq) <<< (CONS_SCALE_SHIFT + 1);
        divisor_o    <= eq_pkg::mag_t'(h_ii + h_qq);
        bin_pipe[0]  <= rd_bin;
        for (int k = 1; k <= LAT; k++) begin
            bin_pipe[k] <= bin_pipe[k-1];
        end
    end

    assign div_stb_o = vld[LAT];
    assign div_bin_o = bin_pipe[LAT];

endmodule

// ==== hdl/lane_divider.sv ====
`timescale 1ns/1ps

module lane_divider (
    input  logic                     clock,
    input  logic                     reset,
    input  eq_pkg::prod_t            dividend_i,
    input  eq_pkg::mag_t             divisor_i,
    input  logic                     stb_i,
    input  logic [eq_pkg::BIN_W-1:0] bin_i,
    output eq_pkg::prod_t            quotient_o,
    output logic                     stb_o,
    output logic [eq_pkg::BIN_W-1:0] bin_o
);

    localparam int NB  = eq_pkg::PROD_W;
    localparam int MW  = eq_pkg::MAG_W;
    localparam int LAT = eq_pkg::DIV_LATENCY;

    logic [NB-1:0]            num [NB+1];  // dividend bits out, quotient bits in
    logic [MW-1:0]            rem [NB+1];
    logic [MW-1:0]            den [NB+1];
    logic                     neg [NB+1];
    logic [LAT-1:0]           stb_pipe;
    logic [eq_pkg::BIN_W-1:0] bin_pipe [LAT];

    always_ff @(posedge clock) begin
        num[0] <= dividend_i[NB-1] ? NB'(-dividend_i) : NB'(dividend_i);
        rem[0] <= '0;
        den[0] <= divisor_i;
        neg[0] <= dividend_i[NB-1];
    end

    // restoring division, one quotient bit per stage, msb first
    for (genvar s = 0; s < NB; s++) begin : g_bit
        logic [MW:0] trial;
        logic [MW:0] diff;
        logic        fits;

        assign trial = {rem[s], num[s][NB-1]};
        assign diff  = trial - {1'b0, den[s]};
        assign fits  = trial >= {1'b0, den[s]}; // always true for a zero divisor

        always_ff @(posedge clock) begin
            rem[s+1] <= fits ? diff[MW-1:0] : trial[MW-1:0];
            num[s+1] <= {num[s][NB-2:0], fits};
            den[s+1] <= den[s];
            neg[s+1] <= neg[s];
        end
    end

    always_ff @(posedge clock) begin
        quotient_o  <= neg[NB] ? -num[NB] : num[NB];
        bin_pipe[0] <= bin_i;
        for (int k = 1; k < LAT; k++) begin
            bin_pipe[k] <= bin_pipe[k-1];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            stb_pipe <= '0;
        end else begin
            stb_pipe <= {stb_pipe[LAT-2:0], stb_i};
        end
    end

    assign stb_o = stb_pipe[LAT-1];
    assign bin_o = bin_pipe[LAT-1];

endmodule

// ==== hdl/output_packer.sv ====
`timescale 1ns/1ps

module output_packer (
    input  logic                        clock,
    input  logic                        reset,
    input  eq_pkg::prod_t               quot_i_i,
    input  eq_pkg::prod_t               quot_q_i,
    input  logic                        stb_i,
    input  logic [eq_pkg::BIN_W-1:0]    bin_i,
    output logic [2*eq_pkg::SAMPLE_W-1:0] sample_o,
    output logic                        sample_stb_o
);

    localparam int SW = eq_pkg::SAMPLE_W;
    localparam int PW = eq_pkg::PROD_W;

    logic keep;

    assign keep = stb_i && eq_pkg::DATA_MASK[bin_i]; // pilots, DC and guards dropped

    always_ff @(posedge clock) begin
        if (reset) begin
            sample_stb_o <= 1'b0;
        end else begin
            sample_stb_o <= keep;
        end
    end

    always_ff @(posedge clock) begin
        if (keep) begin
            sample_o <= {quot_i_i[PW-1], quot_i_i[SW-2:0],
                         quot_q_i[PW-1], quot_q_i[SW-2:0]};
        end
    end

endmodule

// ==== hdl/equalizer_top.sv ====
`timescale 1ns/1ps

module equalizer_top #(
    parameter int CONS_SCALE_SHIFT = 2
) (
    input  logic                          clock,
    input  logic                          reset,
    input  eq_pkg::cplx_t                 sample_i,
    input  logic                          sample_stb_i,
    output logic [2*eq_pkg::SAMPLE_W-1:0] sample_o,
    output logic                          sample_stb_o,
    output eq_pkg::prod_t                 pilot_sum_i_o,
    output eq_pkg::prod_t                 pilot_sum_q_o,
    output logic                          pilot_sum_stb_o
);

    localparam int NL      = eq_pkg::NUM_LANES;
    localparam int POL_LEN = $bits(eq_pkg::POLARITY);
    localparam int SYM_W   = $clog2(POL_LEN);

    logic [eq_pkg::BIN_W-1:0] bin_cnt;
    logic [SYM_W-1:0]         sym_idx;
    logic [1:0]               lts_syms;  // training symbols seen, stops at 2
    logic                     chan_ready;
    logic                     lts_stb;
    logic                     data_stb;
    logic [eq_pkg::BIN_W-1:0] pc_raddr;
    logic [eq_pkg::BIN_W-1:0] sf_raddr;
    eq_pkg::cplx_t            h_a;
    eq_pkg::cplx_t            h_b;
    eq_pkg::prod_t            dividend [NL];
    eq_pkg::prod_t            quotient [NL];
    eq_pkg::mag_t             divisor;
    logic                     div_stb;
    logic [eq_pkg::BIN_W-1:0] div_bin;
    logic                     lane_stb [NL];
    logic [eq_pkg::BIN_W-1:0] lane_bin [NL];

    // data may follow the last training bin before the mean is fully written
    assign lts_stb  = sample_stb_i && !lts_syms[1];
    assign data_stb = sample_stb_i && lts_syms[1];

    always_ff @(posedge clock) begin
        if (reset) begin
            bin_cnt  <= '0;
            sym_idx  <= '0;
            lts_syms <= '0;
        end else if (sample_stb_i) begin
            bin_cnt <= bin_cnt + 1'b1;
            if (bin_cnt == '1) begin
                if (!lts_syms[1]) begin
                    lts_syms <= lts_syms + 1'b1;
                end
                if (chan_ready) begin
                    sym_idx <= (sym_idx == SYM_W'(POL_LEN - 1)) ? '0 : sym_idx + 1'b1;
                end
            end
        end
    end

    lts_averager i_lts_averager (
        .clock       (clock),
        .reset       (reset),
        .sample_i    (sample_i),
        .sample_stb_i(lts_stb),
        .raddr_a_i   (pc_raddr),
        .h_a_o       (h_a),
        .raddr_b_i   (sf_raddr),
        .h_b_o       (h_b),
        .chan_ready_o(chan_ready)
    );

    pilot_correlator i_pilot_correlator (
        .clock          (clock),
        .reset          (reset),
        .sample_i       (sample_i),
        .sample_stb_i   (data_stb),
        .bin_i          (bin_cnt),
        .sym_idx_i      (sym_idx),
        .h_raddr_o      (pc_raddr),
        .h_i            (h_a),
        .pilot_sum_i_o  (pilot_sum_i_o),
        .pilot_sum_q_o  (pilot_sum_q_o),
        .pilot_sum_stb_o(pilot_sum_stb_o)
    );

    symbol_feeder #(
        .CONS_SCALE_SHIFT(CONS_SCALE_SHIFT)
    ) i_symbol_feeder (
        .clock       (clock),
        .reset       (reset),
        .sample_i    (sample_i),
        .sample_stb_i(data_stb),
        .bin_i       (bin_cnt),
        .h_raddr_o   (sf_raddr),
        .h_i         (h_b),
        .dividend_i_o(dividend[0]),
        .dividend_q_o(dividend[1]),
        .divisor_o   (divisor),
        .div_stb_o   (div_stb),
        .div_bin_o   (div_bin)
    );

    // lane 0 divides the I product, lane 1 the Q product
    for (genvar l = 0; l < NL; l++) begin : g_lane
        lane_divider i_lane_divider (
            .clock     (clock),
            .reset     (reset),
            .dividend_i(dividend[l]),
            .divisor_i (divisor),
            .stb_i     (div_stb),
            .bin_i     (div_bin),
            .quotient_o(quotient[l]),
            .stb_o     (lane_stb[l]),
            .bin_o     (lane_bin[l])
        );
    end

    output_packer i_output_packer (
        .clock       (clock),
        .reset       (reset),
        .quot_i_i    (quotient[0]),
        .quot_q_i    (quotient[1]),
        .stb_i       (lane_stb[0]),
        .bin_i       (lane_bin[0]),
        .sample_o    (sample_o),
        .sample_stb_o(sample_stb_o)
    );

endmodule

// ==== tests/equalizer_asserts.sv ====
`timescale 1ns/1ps

module equalizer_asserts (
    input logic clock,
    input logic reset,
    input logic chan_ready_i,
    input logic out_stb_i,
    input logic pilot_stb_i
);

    logic [6:0] since_pilot; // cycles since last pilot sum, saturating

    always_ff @(posedge clock) begin
        if (reset) begin
            since_pilot <= '1;
        end else if (pilot_stb_i) begin
            since_pilot <= '0;
        end else if (since_pilot != '1) begin
            since_pilot <= since_pilot + 1'b1;
        end
    end

    quiet_after_reset: assert property (
        @(posedge clock) reset |=> !out_stb_i && !pilot_stb_i
    ) else $error("strobe high in or right after a reset cycle");

    out_needs_channel: assert property (
        @(posedge clock) disable iff (reset) out_stb_i |-> chan_ready_i
    ) else $error("output strobe before the channel estimate is ready");

    // one pilot sum per symbol, and a symbol takes at least 64 cycles
    pilot_spacing: assert property (
        @(posedge clock) disable iff (reset) pilot_stb_i |-> since_pilot >= 7'd63
    ) else $error("two pilot sums within 64 cycles");

endmodule

bind equalizer_top equalizer_asserts i_equalizer_asserts (
    .clock       (clock),
    .reset       (reset),
    .chan_ready_i(chan_ready),
    .out_stb_i   (sample_stb_o),
    .pilot_stb_i (pilot_sum_stb_o)
);

// ==== tests/equalizer_checks.svh ====
`ifndef EQUALIZER_CHECKS_SVH
`define EQUALIZER_CHECKS_SVH

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] got);
        assert (got === exp) else begin
            report_error($sformatf("Mismatch in %s, %s: expected %0h, actual %0h",
                                   test_name, what, exp, got));
        end
    endtask

    function automatic int rand_range(input int limit);
        return $random(seed) % limit; // -(limit-1) .. limit-1
    endfunction

    function automatic int nonzero_rand(input int limit);
        int v;
        v = rand_range(limit);
        if (v > -16 && v < 16) begin
            v = v + 64;
        end
        return v;
    endfunction

    function automatic int ref_sign(input int k);
        return eq_pkg::LTS_REF[k] ? -1 : 1;
    endfunction

    task automatic apply_reset();
        @(posedge clock);
        reset        <= 1'b1;
        sample_stb_i <= 1'b0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        exp_words.delete();
        exp_pilots.delete();
        out_count   = 0;
        pilot_count = 0;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            sample_stb_i <= 1'b0;
        end
    endtask

    // leaves the strobe high after bin 63 so symbols can follow without a gap
    task automatic drive_symbol(input int gap_max);
        int gap;
        for (int k = 0; k < eq_pkg::NUM_BINS; k++) begin
            gap = 0;
            if (gap_max > 0) begin
                gap = rand_range(gap_max + 1);
                gap = (gap < 0) ? -gap : gap;
            end
            drive_idle(gap);
            @(posedge clock);
            sample_i.i   <= sym_i[k][eq_pkg::SAMPLE_W-1:0];
            sample_i.q   <= sym_q[k][eq_pkg::SAMPLE_W-1:0];
            sample_stb_i <= 1'b1;
        end
    endtask

    task automatic send_training(input int gap_max);
        for (int t = 0; t < 2; t++) begin
            for (int k = 0; k < eq_pkg::NUM_BINS; k++) begin
                sym_i[k] = lts_i[t][k];
                sym_q[k] = lts_q[t][k];
            end
            drive_symbol(gap_max);
        end
        train_model();
    endtask

    task automatic expect_symbol();
        for (int k = 0; k < eq_pkg::NUM_BINS; k++) begin
            if (eq_pkg::DATA_MASK[k]) begin
                exp_words.push_back(expected_word(k));
            end
        end
        exp_pilots.push_back(expected_pilot());
        model_sym++;
    endtask

    task automatic send_data(input int gap_max);
        expect_symbol();
        drive_symbol(gap_max);
    endtask

    // second symbol is the sign-corrected first plus a little noise
    task automatic fill_random_training();
        for (int k = 0; k < eq_pkg::NUM_BINS; k++) begin
            lts_i[0][k] = nonzero_rand(2000);
            lts_q[0][k] = nonzero_rand(2000);
            lts_i[1][k] = ref_sign(k) * lts_i[0][k] + rand_range(4);
            lts_q[1][k] = ref_sign(k) * lts_q[0][k] + rand_range(4);
        end
    endtask

    task automatic fill_random_data();
        for (int k = 0; k < eq_pkg::NUM_BINS; k++) begin
            sym_i[k] = rand_range(4000);
            sym_q[k] = rand_range(4000);
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        drive_idle(1);
        while (exp_words.size() + exp_pilots.size() != 0) begin
            @(posedge clock);
            cycles++;
            assert (cycles < DRAIN_LIMIT) else begin
                report_error($sformatf("%s: timed out, %0d words and %0d pilot sums never came",
                                       test_name, exp_words.size(), exp_pilots.size()));
            end
        end
        drive_idle(100); // any extra strobe shows up in the monitor here
    endtask

    task automatic reset_and_training_quiet();
        test_name = "reset_quiet";
        apply_reset();
        fill_random_training();
        send_training(0);
        drive_idle(80);
        check_value("strobes before data", 0, out_count + pilot_count);
    endtask

    task automatic identity_channel();
        test_name = "identity_channel";
        apply_reset();
        for (int k = 0; k < eq_pkg::NUM_BINS; k++) begin
            lts_i[0][k] = ref_sign(k) * 1024;   // H ends up real at +-1024
            lts_q[0][k] = 0;
            lts_i[1][k] = 1024;
            lts_q[1][k] = 0;
        end
        send_training(0);
        for (int k = 0; k < eq_pkg::NUM_BINS; k++) begin
            sym_i[k] = (k - 32) * 256;
            sym_q[k] = (31 - k) * 128;
        end
        send_data(0);
        wait_drained();
        check_value("output count", eq_pkg::NUM_DATA, out_count);
    endtask

    task automatic pilot_polarity();
        test_name = "pilot_polarity";
        apply_reset();
        fill_random_training();
        send_training(0);
        fill_random_data();
        for (int p = 0; p < 4; p++) begin
            sym_i[eq_pkg::PILOT_BIN[p]] = 700 - 300 * p;
            sym_q[eq_pkg::PILOT_BIN[p]] = 150 * p - 200;
        end
        repeat (3) send_data(0);
        wait_drained();
        check_value("pilot sum count", 3, pilot_count);
    endtask

    task automatic back_to_back_symbols();
        test_name   = "back_to_back";
        out_count   = 0;
        pilot_count = 0;
        for (int s = 0; s < 4; s++) begin
            fill_random_data();
            send_data(0);
        end
        wait_drained();
        check_value("output count", 4 * eq_pkg::NUM_DATA, out_count);
        check_value("pilot sum count", 4, pilot_count);
    endtask

    task automatic random_traffic();
        test_name = "random_traffic";
        apply_reset();
        fill_random_training();
        send_training(3);
        for (int s = 0; s < 6; s++) begin
            fill_random_data();
            send_data(3);
        end
        wait_drained();
        check_value("output count", 6 * eq_pkg::NUM_DATA, out_count);
        check_value("pilot sum count", 6, pilot_count);
    endtask

`endif

// ==== tests/equalizer_tb.sv ====
`timescale 1ns/1ps

module equalizer_tb;

    localparam int SCALE_SHIFT = 2;
    localparam int DRAIN_LIMIT = 1000; // cycles to wait for the last expected output

    logic                          clock = 1'b0;
    logic                          reset;
    eq_pkg::cplx_t                 sample_i;
    logic                          sample_stb_i;
    logic [2*eq_pkg::SAMPLE_W-1:0] sample_o;
    logic                          sample_stb_o;
    eq_pkg::prod_t                 pilot_sum_i_o;
    eq_pkg::prod_t                 pilot_sum_q_o;
    logic                          pilot_sum_stb_o;

    integer      seed = 32'h2901_266a;
    string       test_name = "none";
    int          out_count = 0;
    int          pilot_count = 0;
    int          model_sym = 0;   // data symbols since training
    int          lts_i [2][64];
    int          lts_q [2][64];
    int          h_i [64];
    int          h_q [64];
    int          sym_i [64];      // symbol about to be driven
    int          sym_q [64];
    logic [31:0] exp_words [$];
    logic [63:0] exp_pilots [$];

    always #2 clock = ~clock;

    equalizer_top #(
        .CONS_SCALE_SHIFT(SCALE_SHIFT)
    ) i_equalizer_top (
        .clock          (clock),
        .reset          (reset),
        .sample_i       (sample_i),
        .sample_stb_i   (sample_stb_i),
        .sample_o       (sample_o),
        .sample_stb_o   (sample_stb_o),
        .pilot_sum_i_o  (pilot_sum_i_o),
        .pilot_sum_q_o  (pilot_sum_q_o),
        .pilot_sum_stb_o(pilot_sum_stb_o)
    );

    `include "equalizer_checks.svh"

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    // H[k] is the mean of the first and the sign-corrected second training value
    function automatic void train_model();
        int b_i;
        int b_q;
        for (int k = 0; k < eq_pkg::NUM_BINS; k++) begin
            b_i = eq_pkg::LTS_REF[k] ? -lts_i[1][k] : lts_i[1][k];
            b_q = eq_pkg::LTS_REF[k] ? -lts_q[1][k] : lts_q[1][k];
            h_i[k] = (lts_i[0][k] + b_i) >>> 1;
            h_q[k] = (lts_q[0][k] + b_q) >>> 1;
        end
        model_sym = 0;
    endfunction

    // scaled x * conj(H) over |H|^2 with sign plus low 15 bits kept per lane
    function automatic logic [31:0] expected_word(input int k);
        int num_i;
        int num_q;
        int mag;
        int quo_i;
        int quo_q;
        num_i = (sym_i[k] * h_i[k] + sym_q[k] * h_q[k]) * (2 ** (SCALE_SHIFT + 1));
        num_q = (sym_q[k] * h_i[k] - sym_i[k] * h_q[k]) * (2 ** (SCALE_SHIFT + 1));
        mag   = (h_i[k] * h_i[k] + h_q[k] * h_q[k]) & ((1 << eq_pkg::MAG_W) - 1);
        quo_i = num_i / mag; // rounds toward zero
        quo_q = num_q / mag;
        return {quo_i[31], quo_i[14:0], quo_q[31], quo_q[14:0]};
    endfunction

    function automatic logic [63:0] expected_pilot();
        int   acc_i;
        int   acc_q;
        int   k;
        int   c_i;
        int   c_q;
        logic neg;
        acc_i = 0;
        acc_q = 0;
        for (int p = 0; p < 4; p++) begin
            k   = eq_pkg::PILOT_BIN[p];
            neg = eq_pkg::POLARITY[model_sym % $bits(eq_pkg::POLARITY)] ^ eq_pkg::PILOT_FLIP[p];
            c_i = neg ? -sym_i[k] : sym_i[k];   // conjugate of the pilot
            c_q = neg ? sym_q[k] : -sym_q[k];
            acc_i += c_i * h_i[k] - c_q * h_q[k];
            acc_q += c_i * h_q[k] + c_q * h_i[k];
        end
        return {acc_i, acc_q};
    endfunction

    always @(negedge clock) begin
        if (!reset && sample_stb_o) begin
            out_count++;
            assert (exp_words.size() != 0) else begin
                report_error($sformatf("%s: output word arrived with none expected", test_name));
            end
            check_value($sformatf("sample_o #%0d", out_count), exp_words.pop_front(), sample_o);
        end
        if (!reset && pilot_sum_stb_o) begin
            pilot_count++;
            assert (exp_pilots.size() != 0) else begin
                report_error($sformatf("%s: pilot sum arrived with none expected", test_name));
            end
            check_value($sformatf("pilot_sum #%0d", pilot_count), exp_pilots.pop_front(),
                        {pilot_sum_i_o, pilot_sum_q_o});
        end
    end

    initial begin
        reset        = 1'b1;
        sample_i     = '0;
        sample_stb_i = 1'b0;
        reset_and_training_quiet();
        identity_channel();
        pilot_polarity();
        back_to_back_symbols();   // carries on the symbol count of the pilot test
        random_traffic();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+tests
hdl/eq_pkg.sv
hdl/chan_ram.sv
hdl/lts_averager.sv
hdl/pilot_correlator.sv
hdl/symbol_feeder.sv
hdl/lane_divider.sv
hdl/output_packer.sv
hdl/equalizer_top.sv
tests/equalizer_asserts.sv
tests/equalizer_tb.sv
